//--- cuStatePkg.sv
package cuStatePkg;

	// Microstate numbering matches the microprogram ROM addresses
	typedef enum logic [7:0]
	{
		stReset0 = 8'd0, stReset1 = 8'd1, stReset2 = 8'd2,
		stFetch0 = 8'd3, stFetch1 = 8'd4, stFetch2 = 8'd5, stFetch3 = 8'd6,
		stSethi0 = 8'd7, stSethi1 = 8'd8,
		stBranch = 8'd9,
		stBxTrue0 = 8'd10, stBxTrue1 = 8'd11,
		stBxFalse0 = 8'd12, stBxFalse1 = 8'd13,
		stCall0 = 8'd18, stCall1 = 8'd19, stCall2 = 8'd20,
		stArithReg = 8'd34, stArithImm = 8'd35,
		stArithCcReg = 8'd36, stArithCcImm = 8'd37, stArithEnd = 8'd38,
		stLoadReg = 8'd39, stLoadImm = 8'd40, stLoadWait = 8'd41,
		stLoadWrite = 8'd42, stLoadEnd = 8'd43,
		stStoreReg = 8'd44, stStoreImm = 8'd45, stStoreData = 8'd46,
		stStoreWait = 8'd47, stStoreEnd = 8'd48,
		stFlow0 = 8'd83, stFlow1 = 8'd84, stFlow2 = 8'd85
	} microState;

	// Next-state source
	typedef enum logic [2:0]
	{
		nsJump = 3'b010,
		nsNext = 3'b011,
		nsDecode = 3'b100,
		nsCond = 3'b110
	} nextMode;

	// Status tested by nsCond
	typedef enum logic
	{
		condMem = 1'b0,
		condBranch = 1'b1
	} condSel;

endpackage

//--- cuCtrlPkg.sv
package cuCtrlPkg;

	// Datapath select fields
	typedef logic [2:0] aluSrcSel;
	typedef logic [1:0] rfPortSel;
	typedef logic [1:0] sseSel;

	typedef logic [31:0] instrWord;

	// Instruction field positions
	localparam int OpHi = 31;
	localparam int OpLo = 30;
	localparam int Op2Hi = 24;
	localparam int Op2Lo = 22;
	localparam int Op3Hi = 24;
	localparam int Op3Lo = 19;

	// i bit, immediate second operand
	localparam int ImmBit = 13;

	// op encodings
	localparam logic [1:0] OpFormat2 = 2'b00;
	localparam logic [1:0] OpCall = 2'b01;
	localparam logic [1:0] OpArith = 2'b10;
	localparam logic [1:0] OpMem = 2'b11;

	// op2 encodings within format 2
	localparam logic [2:0] Op2Bicc = 3'b010;
	localparam logic [2:0] Op2Sethi = 3'b100;

endpackage

//--- instrDecoder.sv
module instrDecoder (
	input cuCtrlPkg::instrWord instruction,
	output cuStatePkg::microState decodeTarget
);

	logic [1:0] op;
	logic [2:0] op2;
	logic [5:0] op3;
	logic immForm;

	assign op = instruction[cuCtrlPkg::OpHi:cuCtrlPkg::OpLo];
	assign op2 = instruction[cuCtrlPkg::Op2Hi:cuCtrlPkg::Op2Lo];
	assign op3 = instruction[cuCtrlPkg::Op3Hi:cuCtrlPkg::Op3Lo];
	assign immForm = instruction[cuCtrlPkg::ImmBit];

	always_comb
	begin
		// Unsupported encodings just advance the PC
		decodeTarget = cuStatePkg::stFlow0;
		case (op)
			cuCtrlPkg::OpCall:
				decodeTarget = cuStatePkg::stCall0;
			cuCtrlPkg::OpFormat2:
			begin
				if (op2 == cuCtrlPkg::Op2Sethi)
					decodeTarget = cuStatePkg::stSethi0;
				else if (op2 == cuCtrlPkg::Op2Bicc)
					decodeTarget = cuStatePkg::stBranch;
			end
			cuCtrlPkg::OpArith:
			begin
				// Upper half of op3 is not arithmetic
				if (!op3[5])
				begin
					// op3 bit 4 picks the forms that set condition codes
					case ({op3[4], immForm})
						2'b00: decodeTarget = cuStatePkg::stArithReg;
						2'b01: decodeTarget = cuStatePkg::stArithImm;
						2'b10: decodeTarget = cuStatePkg::stArithCcReg;
						2'b11: decodeTarget = cuStatePkg::stArithCcImm;
					endcase
				end
			end
			cuCtrlPkg::OpMem:
			begin
				// Stores have op3 bit 2 set
				if (op3[2])
					decodeTarget = immForm ? cuStatePkg::stStoreImm : cuStatePkg::stStoreReg;
				else
					decodeTarget = immForm ? cuStatePkg::stLoadImm : cuStatePkg::stLoadReg;
			end
		endcase
	end

endmodule

//--- microSequencer.sv
module microSequencer (
	input logic clk,
	input logic rst,
	input cuStatePkg::nextMode mode,
	input cuStatePkg::microState target,
	input cuStatePkg::condSel condition,
	input cuStatePkg::microState decodeTarget,
	input logic memDone,
	input logic condTrue,
	output cuStatePkg::microState state
);

	cuStatePkg::microState stepState;
	cuStatePkg::microState nextState;
	logic status;

	// Increment only lands on a defined state where the table uses it
	assign stepState = cuStatePkg::microState'(state + 8'd1);
	assign status = (condition == cuStatePkg::condBranch) ? condTrue : memDone;

	always_comb
	begin
		case (mode)
			cuStatePkg::nsJump: nextState = target;
			cuStatePkg::nsNext: nextState = stepState;
			cuStatePkg::nsDecode: nextState = decodeTarget;
			// Wait states name themselves as target
			cuStatePkg::nsCond: nextState = status ? stepState : target;
			default: nextState = cuStatePkg::stFetch0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= cuStatePkg::stReset0;
		else
			state <= nextState;
	end

	// ********************************************************
	// Checks against the microstore sequencing fields
	// ********************************************************

	assert property (@(posedge clk) disable iff (rst)
		state inside {[cuStatePkg::stReset0:cuStatePkg::stBxFalse1],
			[cuStatePkg::stCall0:cuStatePkg::stCall2],
			[cuStatePkg::stArithReg:cuStatePkg::stStoreEnd],
			[cuStatePkg::stFlow0:cuStatePkg::stFlow2]})
		else $error("Microstate register holds an undefined state");

	// Dispatch only once the instruction register is loaded
	assert property (@(posedge clk) disable iff (rst)
		mode == cuStatePkg::nsDecode |-> state == cuStatePkg::stFetch3)
		else $error("Decode dispatch requested outside the last fetch state");

endmodule

//--- microstore.sv
module microstore (
	input cuStatePkg::microState state,
	output cuStatePkg::nextMode mode,
	output cuStatePkg::microState target,
	output cuStatePkg::condSel condition,
	output logic irEnable, rfEnable, marEnable, mdrEnable, memValid,
	output logic pcEnable, npcEnable, psrEnable, clear,
	output logic mdrSelect, ramOpSelect, aluOpSelect,
	output cuCtrlPkg::rfPortSel rfCSelect, rfASelect,
	output cuCtrlPkg::sseSel sseSelect,
	output cuCtrlPkg::aluSrcSel aluASelect, aluBSelect
);

	// Mode, target, condition, then the datapath word in unpacking order
	logic [35:0] uInstr;

	always_comb
	begin
		case (state)
			// ************************ Reset ************************
			cuStatePkg::stReset0: uInstr = {cuStatePkg::nsJump, cuStatePkg::stReset1,
				cuStatePkg::condMem, 24'b000000001_000_00_00_00_000_000};
			cuStatePkg::stReset1: uInstr = {cuStatePkg::nsNext, cuStatePkg::stFetch0,
				cuStatePkg::condMem, 24'b000000100_000_00_00_00_101_011};
			cuStatePkg::stReset2: uInstr = {cuStatePkg::nsNext, cuStatePkg::stFetch0,
				cuStatePkg::condMem, 24'b000000000_000_00_00_00_000_000};
			// ************************ Fetch ************************
			cuStatePkg::stFetch0: uInstr = {cuStatePkg::nsNext, cuStatePkg::stFetch0,
				cuStatePkg::condMem, 24'b001000000_000_00_00_00_001_101};
			cuStatePkg::stFetch1: uInstr = {cuStatePkg::nsNext, cuStatePkg::stFetch0,
				cuStatePkg::condMem, 24'b000010000_000_00_00_00_000_000};
			// Hold until the instruction word arrives
			cuStatePkg::stFetch2: uInstr = {cuStatePkg::nsCond, cuStatePkg::stFetch2,
				cuStatePkg::condMem, 24'b100000000_000_00_00_00_000_000};
			cuStatePkg::stFetch3: uInstr = {cuStatePkg::nsDecode, cuStatePkg::stFetch0,
				cuStatePkg::condMem, 24'b000000000_000_00_00_00_000_000};
			// ************************ SETHI ************************
			cuStatePkg::stSethi0: uInstr = {cuStatePkg::nsNext, cuStatePkg::stFetch0,
				cuStatePkg::condMem, 24'b010000000_000_00_00_01_101_001};
			cuStatePkg::stSethi1: uInstr = {cuStatePkg::nsJump, cuStatePkg::stFlow0,
				cuStatePkg::condMem, 24'b000000000_000_00_00_00_000_000};
			// ************************ Branch ***********************
			cuStatePkg::stBranch: uInstr = {cuStatePkg::nsCond, cuStatePkg::stBxFalse0,
				cuStatePkg::condBranch, 24'b000000000_000_00_00_00_000_000};
			// Taken, PC and nPC from the displacement
			cuStatePkg::stBxTrue0: uInstr = {cuStatePkg::nsNext, cuStatePkg::stFetch0,
				cuStatePkg::condMem, 24'b000001100_000_00_00_10_001_001};
			cuStatePkg::stBxTrue1: uInstr = {cuStatePkg::nsJump, cuStatePkg::stFetch0,
				cuStatePkg::condMem, 24'b000000000_000_00_00_00_000_000};
			cuStatePkg::stBxFalse0: uInstr = {cuStatePkg::nsNext, cuStatePkg::stFetch0,
				cuStatePkg::condMem, 24'b000001100_000_00_00_00_010_011};
			cuStatePkg::stBxFalse1: uInstr = {cuStatePkg::nsJump, cuStatePkg::stFetch0,
				cuStatePkg::condMem, 24'b000000000_000_00_00_00_000_000};
			// ************************ CALL *************************
			cuStatePkg::stCall0: uInstr = {cuStatePkg::nsNext, cuStatePkg::stFetch0,
				cuStatePkg::condMem, 24'b010000000_000_01_00_00_001_101};
			cuStatePkg::stCall1: uInstr = {cuStatePkg::nsNext, cuStatePkg::stFetch0,
				cuStatePkg::condMem, 24'b000001100_000_00_00_11_001_001};
			cuStatePkg::stCall2: uInstr = {cuStatePkg::nsJump, cuStatePkg::stFetch0,
				cuStatePkg::condMem, 24'b000000000_000_00_00_00_000_000};
			// ********************* Arithmetic **********************
			cuStatePkg::stArithReg: uInstr = {cuStatePkg::nsJump, cuStatePkg::stArithEnd,
				cuStatePkg::condMem, 24'b010000000_001_00_00_00_000_000};
			cuStatePkg::stArithImm: uInstr = {cuStatePkg::nsJump, cuStatePkg::stArithEnd,
				cuStatePkg::condMem, 24'b010000000_001_00_00_00_000_001};
			cuStatePkg::stArithCcReg: uInstr = {cuStatePkg::nsJump, cuStatePkg::stArithEnd,
				cuStatePkg::condMem, 24'b010000010_001_00_00_00_000_000};
			cuStatePkg::stArithCcImm: uInstr = {cuStatePkg::nsNext, cuStatePkg::stFetch0,
				cuStatePkg::condMem, 24'b010000010_001_00_00_00_000_001};
			cuStatePkg::stArithEnd: uInstr = {cuStatePkg::nsJump, cuStatePkg::stFlow0,
				cuStatePkg::condMem, 24'b000000000_000_00_00_00_000_000};
			// ************************ Load *************************
			cuStatePkg::stLoadReg: uInstr = {cuStatePkg::nsJump, cuStatePkg::stLoadWait,
				cuStatePkg::condMem, 24'b001000000_010_00_00_00_000_000};
			cuStatePkg::stLoadImm: uInstr = {cuStatePkg::nsNext, cuStatePkg::stFetch0,
				cuStatePkg::condMem, 24'b001000000_010_00_00_00_000_001};
			cuStatePkg::stLoadWait: uInstr = {cuStatePkg::nsCond, cuStatePkg::stLoadWait,
				cuStatePkg::condMem, 24'b000110000_010_00_00_00_000_000};
			cuStatePkg::stLoadWrite: uInstr = {cuStatePkg::nsNext, cuStatePkg::stFetch0,
				cuStatePkg::condMem, 24'b010000000_000_00_00_00_101_010};
			cuStatePkg::stLoadEnd: uInstr = {cuStatePkg::nsJump, cuStatePkg::stFlow0,
				cuStatePkg::condMem, 24'b000000000_000_00_00_00_000_000};
			// ************************ Store ************************
			cuStatePkg::stStoreReg: uInstr = {cuStatePkg::nsJump, cuStatePkg::stStoreData,
				cuStatePkg::condMem, 24'b001000000_000_00_00_00_000_000};
			cuStatePkg::stStoreImm: uInstr = {cuStatePkg::nsNext, cuStatePkg::stFetch0,
				cuStatePkg::condMem, 24'b001000000_000_00_00_00_000_001};
			// Store data comes through register port A
			cuStatePkg::stStoreData: uInstr = {cuStatePkg::nsNext, cuStatePkg::stFetch0,
				cuStatePkg::condMem, 24'b000100000_110_00_01_00_000_101};
			cuStatePkg::stStoreWait: uInstr = {cuStatePkg::nsCond, cuStatePkg::stStoreWait,
				cuStatePkg::condMem, 24'b000010000_010_00_00_00_000_000};
			cuStatePkg::stStoreEnd: uInstr = {cuStatePkg::nsJump, cuStatePkg::stFlow0,
				cuStatePkg::condMem, 24'b000000000_000_00_00_00_000_000};
			// ********************* Instruction flow ****************
			cuStatePkg::stFlow0: uInstr = {cuStatePkg::nsNext, cuStatePkg::stFetch0,
				cuStatePkg::condMem, 24'b000001000_000_00_00_00_000_000};
			cuStatePkg::stFlow1: uInstr = {cuStatePkg::nsNext, cuStatePkg::stFetch0,
				cuStatePkg::condMem, 24'b000000100_000_00_00_00_010_011};
			cuStatePkg::stFlow2: uInstr = {cuStatePkg::nsJump, cuStatePkg::stFetch0,
				cuStatePkg::condMem, 24'b000000000_000_00_00_00_000_000};
			default: uInstr = {cuStatePkg::nsJump, cuStatePkg::stFetch0,
				cuStatePkg::condMem, 24'b000000000_000_00_00_00_000_000};
		endcase
	end

	assign mode = cuStatePkg::nextMode'(uInstr[35:33]);
	assign target = cuStatePkg::microState'(uInstr[32:25]);
	assign condition = cuStatePkg::condSel'(uInstr[24]);
	assign {irEnable, rfEnable, marEnable, mdrEnable, memValid, pcEnable, npcEnable, psrEnable,
		clear, mdrSelect, ramOpSelect, aluOpSelect, rfCSelect, rfASelect, sseSelect,
		aluASelect, aluBSelect} = uInstr[23:0];

	// ALU opcode taken from the instruction only where the decoder dispatches arithmetic
	always_comb
	begin
		assert (!aluOpSelect || state inside {[cuStatePkg::stArithReg:cuStatePkg::stArithCcImm]})
			else $error("ALU opcode select high outside the arithmetic start states");
		assert (!(memValid && irEnable))
			else $error("Memory request active while the instruction register loads");
	end

endmodule

//--- controlUnit.sv
module controlUnit (
	input logic clk,
	input logic rst,
	input cuCtrlPkg::instrWord instruction,
	input logic memDone,
	input logic condTrue,
	output cuStatePkg::microState state,
	output logic irEnable, rfEnable, marEnable, mdrEnable, memValid,
	output logic pcEnable, npcEnable, psrEnable, clear,
	output logic mdrSelect, ramOpSelect, aluOpSelect,
	output cuCtrlPkg::rfPortSel rfCSelect, rfASelect,
	output cuCtrlPkg::sseSel sseSelect,
	output cuCtrlPkg::aluSrcSel aluASelect, aluBSelect
);

	// Sequencing fields from the microstore
	cuStatePkg::nextMode mode;
	cuStatePkg::microState target;
	cuStatePkg::condSel condition;

	cuStatePkg::microState decodeTarget;

	instrDecoder instrDecoder_i (
		.instruction(instruction),
		.decodeTarget(decodeTarget)
	);

	microSequencer microSequencer_i (
		.clk(clk),
		.rst(rst),
		.mode(mode),
		.target(target),
		.condition(condition),
		.decodeTarget(decodeTarget),
		.memDone(memDone),
		.condTrue(condTrue),
		.state(state)
	);

	microstore microstore_i (
		.state(state),
		.mode(mode),
		.target(target),
		.condition(condition),
		.irEnable(irEnable), .rfEnable(rfEnable), .marEnable(marEnable),
		.mdrEnable(mdrEnable), .memValid(memValid), .pcEnable(pcEnable),
		.npcEnable(npcEnable), .psrEnable(psrEnable), .clear(clear),
		.mdrSelect(mdrSelect), .ramOpSelect(ramOpSelect), .aluOpSelect(aluOpSelect),
		.rfCSelect(rfCSelect), .rfASelect(rfASelect), .sseSelect(sseSelect),
		.aluASelect(aluASelect), .aluBSelect(aluBSelect)
	);

endmodule

//--- controlUnitTbTable.svh
`ifndef CONTROL_UNIT_TB_TABLE_SVH
`define CONTROL_UNIT_TB_TABLE_SVH

// Columns: test name, instruction word, condTrue, expected microstate trace
// Trace runs from stFetch0 back to stFetch0, padded with stFetch0, wait states listed once

localparam int NumRows = 14;
localparam int MaxTrace = 12;

typedef struct {
	string name;
	logic [31:0] instr;
	logic cond;
	logic [0:MaxTrace-1][7:0] trace;
} tableRow;

tableRow rows [NumRows] = '{
	'{"sethi", 32'h03001234, 1'b0,
		{8'd3, 8'd4, 8'd5, 8'd6, 8'd7, 8'd8, 8'd83, 8'd84, 8'd85, 8'd3, 8'd3, 8'd3}},
	'{"branch taken", 32'h10800004, 1'b1,
		{8'd3, 8'd4, 8'd5, 8'd6, 8'd9, 8'd10, 8'd11, 8'd3, 8'd3, 8'd3, 8'd3, 8'd3}},
	'{"branch not taken", 32'h10800004, 1'b0,
		{8'd3, 8'd4, 8'd5, 8'd6, 8'd9, 8'd12, 8'd13, 8'd3, 8'd3, 8'd3, 8'd3, 8'd3}},
	'{"call", 32'h40000010, 1'b0,
		{8'd3, 8'd4, 8'd5, 8'd6, 8'd18, 8'd19, 8'd20, 8'd3, 8'd3, 8'd3, 8'd3, 8'd3}},
	'{"add reg", 32'h86004002, 1'b0,
		{8'd3, 8'd4, 8'd5, 8'd6, 8'd34, 8'd38, 8'd83, 8'd84, 8'd85, 8'd3, 8'd3, 8'd3}},
	'{"add imm", 32'h86006005, 1'b0,
		{8'd3, 8'd4, 8'd5, 8'd6, 8'd35, 8'd38, 8'd83, 8'd84, 8'd85, 8'd3, 8'd3, 8'd3}},
	'{"addcc reg", 32'h86804002, 1'b1,
		{8'd3, 8'd4, 8'd5, 8'd6, 8'd36, 8'd38, 8'd83, 8'd84, 8'd85, 8'd3, 8'd3, 8'd3}},
	'{"addcc imm", 32'h86806005, 1'b0,
		{8'd3, 8'd4, 8'd5, 8'd6, 8'd37, 8'd38, 8'd83, 8'd84, 8'd85, 8'd3, 8'd3, 8'd3}},
	'{"load reg", 32'hC2004002, 1'b0,
		{8'd3, 8'd4, 8'd5, 8'd6, 8'd39, 8'd41, 8'd42, 8'd43, 8'd83, 8'd84, 8'd85, 8'd3}},
	'{"load imm", 32'hC2006008, 1'b1,
		{8'd3, 8'd4, 8'd5, 8'd6, 8'd40, 8'd41, 8'd42, 8'd43, 8'd83, 8'd84, 8'd85, 8'd3}},
	'{"store reg", 32'hC2204002, 1'b0,
		{8'd3, 8'd4, 8'd5, 8'd6, 8'd44, 8'd46, 8'd47, 8'd48, 8'd83, 8'd84, 8'd85, 8'd3}},
	'{"store imm", 32'hC2206008, 1'b0,
		{8'd3, 8'd4, 8'd5, 8'd6, 8'd45, 8'd46, 8'd47, 8'd48, 8'd83, 8'd84, 8'd85, 8'd3}},
	'{"jmpl skipped", 32'h81C3E008, 1'b0,
		{8'd3, 8'd4, 8'd5, 8'd6, 8'd83, 8'd84, 8'd85, 8'd3, 8'd3, 8'd3, 8'd3, 8'd3}},
	'{"unimp skipped", 32'h00000000, 1'b1,
		{8'd3, 8'd4, 8'd5, 8'd6, 8'd83, 8'd84, 8'd85, 8'd3, 8'd3, 8'd3, 8'd3, 8'd3}}
};

`endif

//--- controlUnitTb.sv
module controlUnitTb;

	`include "controlUnitTbTable.svh"

	localparam int ResetCycles = 10;
	localparam int MaxWait = 3;
	localparam logic [31:0] Seed = 32'hefe6f025;

	logic clk = 1'b0;
	logic rst;
	cuCtrlPkg::instrWord instruction;
	logic memDone;
	logic condTrue;
	cuStatePkg::microState state;
	logic irEnable, rfEnable, marEnable, mdrEnable, memValid;
	logic pcEnable, npcEnable, psrEnable, clear;
	logic mdrSelect, ramOpSelect, aluOpSelect;
	cuCtrlPkg::rfPortSel rfCSelect, rfASelect;
	cuCtrlPkg::sseSel sseSelect;
	cuCtrlPkg::aluSrcSel aluASelect, aluBSelect;

	string testName;
	logic [31:0] curInstr;
	logic curCond;
	int cycleCount = 0;
	int timeoutLimit;

	controlUnit controlUnit_i (
		.clk(clk), .rst(rst), .instruction(instruction),
		.memDone(memDone), .condTrue(condTrue), .state(state),
		.irEnable(irEnable), .rfEnable(rfEnable), .marEnable(marEnable),
		.mdrEnable(mdrEnable), .memValid(memValid), .pcEnable(pcEnable),
		.npcEnable(npcEnable), .psrEnable(psrEnable), .clear(clear),
		.mdrSelect(mdrSelect), .ramOpSelect(ramOpSelect), .aluOpSelect(aluOpSelect),
		.rfCSelect(rfCSelect), .rfASelect(rfASelect), .sseSelect(sseSelect),
		.aluASelect(aluASelect), .aluBSelect(aluBSelect)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutLimit)
		begin
			$display("Run timed out after %0d cycles", cycleCount);
			$display("Simulation failed");
			$fatal(1, "Timeout");
		end
	end

	// ************************************************************
	// Checking helpers
	// ************************************************************

	task automatic abortRun();
		$display("Simulation failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic expectBit(input string what, input logic expected, input logic actual);
		assert (actual === expected)
		else
		begin
			$display("FAIL %s %s: expected %0b actual %0b", testName, what, expected, actual);
			abortRun();
		end
	endtask

	task automatic matchField(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("FAIL %s %s: expected %0d actual %0d", testName, what, expected, actual);
			abortRun();
		end
	endtask

	function automatic logic isWaitState(input logic [7:0] value);
		return value inside {cuStatePkg::stFetch2, cuStatePkg::stLoadWait,
			cuStatePkg::stStoreWait};
	endfunction

	// Entries up to and including the return to stFetch0
	function automatic int traceLength(input logic [0:MaxTrace-1][7:0] trace);
		int len;
		int k;
		len = MaxTrace;
		for (k = MaxTrace - 1; k >= 1; k--)
			if (trace[k] == cuStatePkg::stFetch0)
				len = k + 1;
		return len;
	endfunction

	task automatic checkControls(input logic [7:0] exp);
		matchField("state", 32'(exp), 32'(state));
		expectBit("clear", exp == cuStatePkg::stReset0, clear);
		expectBit("irEnable", exp == cuStatePkg::stFetch2, irEnable);
		expectBit("memValid", exp inside {cuStatePkg::stFetch1, cuStatePkg::stLoadWait,
			cuStatePkg::stStoreWait}, memValid);
		expectBit("aluOpSelect", exp inside {cuStatePkg::stArithReg, cuStatePkg::stArithImm,
			cuStatePkg::stArithCcReg, cuStatePkg::stArithCcImm}, aluOpSelect);
		expectBit("psrEnable", exp inside {cuStatePkg::stArithCcReg,
			cuStatePkg::stArithCcImm}, psrEnable);
		if (exp == cuStatePkg::stReset0)
		begin
			matchField("enables", 32'h0, 32'({irEnable, rfEnable, marEnable, mdrEnable,
				memValid, pcEnable, npcEnable, psrEnable}));
			// Reset state leaves every select at its inactive default
			matchField("selects", 32'h0, 32'({mdrSelect, ramOpSelect, aluOpSelect,
				rfCSelect, rfASelect, sseSelect, aluASelect, aluBSelect}));
		end
		if (exp inside {[cuStatePkg::stArithReg:cuStatePkg::stArithCcImm]})
			expectBit("rfEnable", 1'b1, rfEnable);
		// First state of either branch path loads PC and nPC
		if (exp inside {cuStatePkg::stBxTrue0, cuStatePkg::stBxFalse0})
		begin
			expectBit("pcEnable", 1'b1, pcEnable);
			expectBit("npcEnable", 1'b1, npcEnable);
		end
		if (exp == cuStatePkg::stLoadWait)
			expectBit("mdrEnable", 1'b1, mdrEnable);
		if (exp == cuStatePkg::stStoreData)
		begin
			expectBit("mdrSelect", 1'b1, mdrSelect);
			matchField("rfASelect", 32'h1, 32'(rfASelect));
		end
	endtask

	// Drive on the rising edge, check at the falling edge
	task automatic applyCycle(input logic [7:0] expected, input logic done);
		@(posedge clk);
		instruction <= curInstr;
		condTrue <= curCond;
		memDone <= done;
		@(negedge clk);
		checkControls(expected);
	endtask

	initial
	begin
		int r;
		int k;
		int len;
		int waits;
		rst = 1'b1;
		instruction = '0;
		memDone = 1'b0;
		condTrue = 1'b0;
		curInstr = '0;
		curCond = 1'b0;
		testName = "reset";
		void'($urandom(Seed));

		// Reset plus every trace with all its waits at the maximum, doubled
		timeoutLimit = ResetCycles + 4;
		for (r = 0; r < NumRows; r++)
		begin
			len = traceLength(rows[r].trace);
			timeoutLimit = timeoutLimit + len;
			for (k = 0; k < len; k++)
				if (isWaitState(rows[r].trace[k]))
					timeoutLimit = timeoutLimit + MaxWait;
		end
		timeoutLimit = 2 * timeoutLimit;

		for (k = 0; k < ResetCycles; k++)
		begin
			@(posedge clk);
			if (k == ResetCycles - 1)
				rst <= 1'b0;
			@(negedge clk);
			checkControls(cuStatePkg::stReset0);
		end
		applyCycle(cuStatePkg::stReset1, 1'b0);
		applyCycle(cuStatePkg::stReset2, 1'b0);
		applyCycle(cuStatePkg::stFetch0, 1'b0);

		// ************************************************************
		// Instruction table, each row starts and ends in stFetch0
		// ************************************************************
		for (r = 0; r < NumRows; r++)
		begin
			testName = rows[r].name;
			curInstr = rows[r].instr;
			curCond = rows[r].cond;
			len = traceLength(rows[r].trace);
			for (k = 1; k < len; k++)
			begin
				if (isWaitState(rows[r].trace[k]))
				begin
					// Random memory latency, state must hold meanwhile
					waits = $urandom % (MaxWait + 1);
					repeat (waits) applyCycle(rows[r].trace[k], 1'b0);
				end
				applyCycle(rows[r].trace[k], isWaitState(rows[r].trace[k]));
			end
		end

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

//--- list.f
+incdir+.
cuStatePkg.sv
cuCtrlPkg.sv
instrDecoder.sv
microSequencer.sv
microstore.sv
controlUnit.sv
controlUnitTb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, then look for the failure line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module controlUnitTb -o controlUnitSim -f list.f \
	|| { echo "Verilator build error"; exit 1; }
./obj_dir/controlUnitSim > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
